// File: include/uart_dem_config.svh
// ----------------------------------------------------------------------
// Build-time sizes and fixed header words for the emulated debug UART.
// Include wherever FIFO depths or DII packet fields are needed.
// ----------------------------------------------------------------------

`ifndef UART_DEM_CONFIG_SVH
`define UART_DEM_CONFIG_SVH

// Character FIFOs inside the 16550 register model
`define UART_DEM_TX_DEPTH   16
`define UART_DEM_RX_DEPTH   16

// Outgoing flit buffer in front of debug_out
`define UART_DEM_FLIT_DEPTH 4

// Destination, source and type words lead every packet
`define UART_DEM_HDR_FLITS  3
`define UART_DEM_HOST_ID    16'h0000
`define UART_DEM_EVT_TYPE   16'h4055

`endif

// File: rtl/uart_dem_pkg.sv
// ----------------------------------------------------------------------
// Shared types for the emulated debug UART: DII flits, the register bus
// request and characters. Referenced by scoped name from every block.
// ----------------------------------------------------------------------

`default_nettype none

package uart_dem_pkg;

   // One character as seen by the host and carried in DII payload flits
   typedef logic [7:0] char_t;

   // 16550 register index
   typedef logic [2:0] reg_addr_t;

   // Debug interconnect flit, 18 bits
   typedef struct packed {
      logic        valid;
      logic        last;    // Final flit of a packet
      logic [15:0] data;
   } dii_flit_t;

   // Request from the NASTI bridge to the register model, 12 bits
   typedef struct packed {
      reg_addr_t addr;
      logic      write;
      char_t     wdata;
   } reg_req_t;

endpackage

`default_nettype wire

// File: rtl/uart_dem_fifo.sv
// ----------------------------------------------------------------------
// Show-ahead synchronous FIFO with a payload type parameter. Serves as
// the character FIFOs and as the outgoing flit buffer.
// ----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module uart_dem_fifo #(
   parameter int  DEPTH     = 16,
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t wdata,
   input  logic     pop,
   input  logic     clear,
   output payload_t rdata,
   output logic     empty,
   output logic     full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic             do_push;
   logic             do_pop;

   assign empty   = (count == '0);
   assign full    = (count == CW'(DEPTH));
   assign do_push = push & ~full;    // Dropped when full
   assign do_pop  = pop & ~empty;
   assign rdata   = mem[rd_ptr];     // Head is always visible

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CW'(do_push) - CW'(do_pop);
      end
   end

endmodule

`default_nettype wire

// File: rtl/uart_16550_regs.sv
// ----------------------------------------------------------------------
// 16550-style register file behind the req/ack register bus. Holds the
// transmit and receive character FIFOs and derives IIR and irq.
// ----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_dem_config.svh"

module uart_16550_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   bus_req,
   input  uart_dem_pkg::reg_req_t bus,
   output logic                   bus_ack,
   output uart_dem_pkg::char_t    bus_rdata,
   output uart_dem_pkg::char_t    tx_char,
   output logic                   tx_valid,
   input  logic                   tx_pop,
   input  uart_dem_pkg::char_t    rx_char,
   input  logic                   rx_push,
   output logic                   irq
);

   logic                fire;
   logic                dlab;
   logic [3:0]          ier;
   logic [7:0]          lcr;
   logic [4:0]          mcr;
   uart_dem_pkg::char_t scr;
   uart_dem_pkg::char_t dll;
   uart_dem_pkg::char_t dlm;
   uart_dem_pkg::char_t iir;
   uart_dem_pkg::char_t lsr;
   uart_dem_pkg::char_t rd_data;
   uart_dem_pkg::char_t rx_head;

   logic tx_push, tx_clear, tx_empty, tx_full;
   logic rx_pop, rx_clear, rx_empty;

   assign fire = bus_req & ~bus_ack;   // Each request acts exactly once
   assign dlab = lcr[7];

   assign tx_push  = fire & bus.write & (bus.addr == 3'd0) & ~dlab;
   assign rx_pop   = fire & ~bus.write & (bus.addr == 3'd0) & ~dlab;
   assign tx_clear = fire & bus.write & (bus.addr == 3'd2) & bus.wdata[2];
   assign rx_clear = fire & bus.write & (bus.addr == 3'd2) & bus.wdata[1];

   uart_dem_fifo #(
      .DEPTH     (`UART_DEM_TX_DEPTH),
      .payload_t (uart_dem_pkg::char_t)
   ) u_tx_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (tx_push),
      .wdata (bus.wdata),
      .pop   (tx_pop),
      .clear (tx_clear),
      .rdata (tx_char),
      .empty (tx_empty),
      .full  (tx_full)
   );

   uart_dem_fifo #(
      .DEPTH     (`UART_DEM_RX_DEPTH),
      .payload_t (uart_dem_pkg::char_t)
   ) u_rx_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (rx_push),
      .wdata (rx_char),
      .pop   (rx_pop),
      .clear (rx_clear),
      .rdata (rx_head),
      .empty (rx_empty),
      .full  ()
   );

   assign tx_valid = ~tx_empty;

   // Received data outranks transmitter empty
   always_comb begin
      if (ier[0] && !rx_empty) iir = 8'hC4;
      else if (ier[1] && tx_empty) iir = 8'hC2;
      else iir = 8'hC1;
   end

   assign irq = ~iir[0];
   assign lsr = {1'b0, tx_empty, ~tx_full, 4'b0000, ~rx_empty};

   always_comb begin
      case (bus.addr)
         3'd0:    rd_data = dlab ? dll : (rx_empty ? 8'h00 : rx_head);
         3'd1:    rd_data = dlab ? dlm : {4'b0000, ier};
         3'd2:    rd_data = iir;
         3'd3:    rd_data = lcr;
         3'd4:    rd_data = {3'b000, mcr};
         3'd5:    rd_data = lsr;
         3'd6:    rd_data = 8'hB0;   // CTS, DSR and DCD asserted
         default: rd_data = scr;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bus_ack <= 1'b0;
         ier     <= '0;
         lcr     <= '0;
         mcr     <= '0;
      end else begin
         bus_ack <= fire;
         if (fire && bus.write) begin
            if (bus.addr == 3'd1 && !dlab) ier <= bus.wdata[3:0];
            if (bus.addr == 3'd3) lcr <= bus.wdata;
            if (bus.addr == 3'd4) mcr <= bus.wdata[4:0];
         end
      end
   end

   // Divisor latches are kept for readback only
   always_ff @(posedge clk) begin
      if (fire && bus.write) begin
         if (bus.addr == 3'd0 && dlab) dll <= bus.wdata;
         if (bus.addr == 3'd1 && dlab) dlm <= bus.wdata;
         if (bus.addr == 3'd7) scr <= bus.wdata;
      end
      if (fire) bus_rdata <= rd_data;
   end

endmodule

`default_nettype wire

// File: rtl/uart_dii_bridge.sv
// ----------------------------------------------------------------------
// Converts between the UART character streams and DII packets. Each
// transmit character leaves as a four-flit packet, payload flits in.
// ----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_dem_config.svh"

module uart_dii_bridge (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [15:0]             id,
   input  uart_dem_pkg::char_t     tx_char,
   input  logic                    tx_valid,
   output logic                    tx_pop,
   output uart_dem_pkg::char_t     rx_char,
   output logic                    rx_push,
   input  uart_dem_pkg::dii_flit_t debug_in,
   output logic                    debug_in_ready,
   output uart_dem_pkg::dii_flit_t debug_out,
   input  logic                    debug_out_ready
);

   localparam int HDR = `UART_DEM_HDR_FLITS;
   localparam int HCW = $clog2(HDR + 1);

   logic                    busy;
   logic [1:0]              flit_cnt;
   uart_dem_pkg::char_t     hold_char;
   uart_dem_pkg::dii_flit_t flit_in;
   uart_dem_pkg::dii_flit_t flit_head;
   logic                    flit_push;
   logic                    flit_empty;
   logic                    flit_full;
   logic [HCW-1:0]          hdr_cnt;
   logic                    in_fire;

   assign flit_push = busy & ~flit_full;   // Stall while the buffer is full
   assign tx_pop    = flit_push & (flit_cnt == 2'd3);

   always_comb begin
      flit_in.valid = 1'b1;
      flit_in.last  = (flit_cnt == 2'd3);
      case (flit_cnt)
         2'd0:    flit_in.data = `UART_DEM_HOST_ID;
         2'd1:    flit_in.data = id;
         2'd2:    flit_in.data = `UART_DEM_EVT_TYPE;
         default: flit_in.data = {8'h00, hold_char};
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         flit_cnt <= '0;
      end else if (!busy) begin
         busy     <= tx_valid;
         flit_cnt <= '0;
      end else if (flit_push) begin
         flit_cnt <= flit_cnt + 1'b1;
         if (flit_cnt == 2'd3) busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!busy && tx_valid) hold_char <= tx_char;
   end

   uart_dem_fifo #(
      .DEPTH     (`UART_DEM_FLIT_DEPTH),
      .payload_t (uart_dem_pkg::dii_flit_t)
   ) u_flit_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (flit_push),
      .wdata (flit_in),
      .pop   (debug_out.valid & debug_out_ready),
      .clear (1'b0),
      .rdata (flit_head),
      .empty (flit_empty),
      .full  (flit_full)
   );

   assign debug_out = '{valid: ~flit_empty, last: flit_head.last, data: flit_head.data};

   // Receive side drops the header and forwards each payload low byte
   assign in_fire = debug_in.valid & debug_in_ready;
   assign rx_push = in_fire & (hdr_cnt == HCW'(HDR));
   assign rx_char = debug_in.data[7:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         debug_in_ready <= 1'b0;
         hdr_cnt        <= '0;
      end else begin
         debug_in_ready <= 1'b1;
         if (in_fire) begin
            if (debug_in.last) hdr_cnt <= '0;
            else if (hdr_cnt != HCW'(HDR)) hdr_cnt <= hdr_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/uart_nasti_bridge.sv
// ----------------------------------------------------------------------
// NASTI-lite slave for the UART registers. Accepts one read or write at
// a time and runs it as a single req/ack cycle on the register bus.
// ----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module uart_nasti_bridge (
   input  logic                      clk,
   input  logic                      rst,
   input  uart_dem_pkg::reg_addr_t   ar_addr,
   input  logic                      ar_valid,
   output logic                      ar_ready,
   output uart_dem_pkg::char_t       r_data,
   output logic [1:0]                r_resp,
   output logic                      r_valid,
   input  logic                      r_ready,
   input  uart_dem_pkg::reg_addr_t   aw_addr,
   input  logic                      aw_valid,
   output logic                      aw_ready,
   input  uart_dem_pkg::char_t       w_data,
   input  logic                      w_valid,
   output logic                      w_ready,
   output logic [1:0]                b_resp,
   output logic                      b_valid,
   input  logic                      b_ready,
   output logic                      bus_req,
   output uart_dem_pkg::reg_req_t    bus,
   input  logic                      bus_ack,
   input  uart_dem_pkg::char_t       bus_rdata
);

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} state_t;

   state_t state;
   logic   wr_accept;
   logic   rd_accept;
   logic   resp_done;

   // Address and data must arrive together, and writes win ties
   assign wr_accept = (state == ST_IDLE) & aw_valid & w_valid;
   assign rd_accept = (state == ST_IDLE) & ar_valid & ~wr_accept;

   assign aw_ready = wr_accept;
   assign w_ready  = wr_accept;
   assign ar_ready = rd_accept;

   assign bus_req   = (state == ST_REQ);   // One cycle, acked on the next edge
   assign b_valid   = (state == ST_RESP) & bus.write;
   assign r_valid   = (state == ST_RESP) & ~bus.write;
   assign b_resp    = 2'b00;
   assign r_resp    = 2'b00;
   assign resp_done = (b_valid & b_ready) | (r_valid & r_ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (wr_accept || rd_accept) state <= ST_REQ;
            ST_REQ:  state <= ST_WAIT;
            ST_WAIT: if (bus_ack) state <= ST_RESP;
            default: if (resp_done) state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept) bus <= '{addr: aw_addr, write: 1'b1, wdata: w_data};
      else if (rd_accept) bus <= '{addr: ar_addr, write: 1'b0, wdata: 8'h00};
      if (state == ST_WAIT && bus_ack) r_data <= bus_rdata;
   end

endmodule

`default_nettype wire

// File: rtl/uart_dem_top.sv
// ----------------------------------------------------------------------
// Debug-attached emulated UART. The host reaches the 16550 registers over
// NASTI while characters travel as DII packets on the debug ports.
// ----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module uart_dem_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [15:0]             id,
   input  uart_dem_pkg::reg_addr_t ar_addr,
   input  logic                    ar_valid,
   output logic                    ar_ready,
   output uart_dem_pkg::char_t     r_data,
   output logic [1:0]              r_resp,
   output logic                    r_valid,
   input  logic                    r_ready,
   input  uart_dem_pkg::reg_addr_t aw_addr,
   input  logic                    aw_valid,
   output logic                    aw_ready,
   input  uart_dem_pkg::char_t     w_data,
   input  logic                    w_valid,
   output logic                    w_ready,
   output logic [1:0]              b_resp,
   output logic                    b_valid,
   input  logic                    b_ready,
   input  uart_dem_pkg::dii_flit_t debug_in,
   output logic                    debug_in_ready,
   output uart_dem_pkg::dii_flit_t debug_out,
   input  logic                    debug_out_ready,
   output logic                    irq
);

   logic                   bus_req;
   logic                   bus_ack;
   uart_dem_pkg::reg_req_t bus;
   uart_dem_pkg::char_t    bus_rdata;
   uart_dem_pkg::char_t    tx_char;
   logic                   tx_valid;
   logic                   tx_pop;
   uart_dem_pkg::char_t    rx_char;
   logic                   rx_push;

   uart_nasti_bridge u_nasti (
      .clk       (clk),
      .rst       (rst),
      .ar_addr   (ar_addr),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .r_data    (r_data),
      .r_resp    (r_resp),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .aw_addr   (aw_addr),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .w_data    (w_data),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .b_resp    (b_resp),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .bus_req   (bus_req),
      .bus       (bus),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata)
   );

   uart_16550_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .bus_req   (bus_req),
      .bus       (bus),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata),
      .tx_char   (tx_char),
      .tx_valid  (tx_valid),
      .tx_pop    (tx_pop),
      .rx_char   (rx_char),
      .rx_push   (rx_push),
      .irq       (irq)
   );

   uart_dii_bridge u_dii (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .tx_char         (tx_char),
      .tx_valid        (tx_valid),
      .tx_pop          (tx_pop),
      .rx_char         (rx_char),
      .rx_push         (rx_push),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready)
   );

endmodule

`default_nettype wire

// File: dv/uart_dem_tb.sv
// ----------------------------------------------------------------------
// Random-stimulus testbench for the debug-attached UART. Drives NASTI and
// DII traffic and checks every response against a model of the 16550.
// ----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_dem_config.svh"

module uart_dem_tb;

   localparam int TIMEOUT  = 100;
   localparam int HDR      = `UART_DEM_HDR_FLITS;
   localparam int RX_DEPTH = `UART_DEM_RX_DEPTH;

   logic                    clk;
   logic                    rst;
   logic [15:0]             id;
   uart_dem_pkg::reg_addr_t ar_addr;
   logic                    ar_valid;
   logic                    ar_ready;
   uart_dem_pkg::char_t     r_data;
   logic [1:0]              r_resp;
   logic                    r_valid;
   logic                    r_ready;
   uart_dem_pkg::reg_addr_t aw_addr;
   logic                    aw_valid;
   logic                    aw_ready;
   uart_dem_pkg::char_t     w_data;
   logic                    w_valid;
   logic                    w_ready;
   logic [1:0]              b_resp;
   logic                    b_valid;
   logic                    b_ready;
   uart_dem_pkg::dii_flit_t debug_in;
   logic                    debug_in_ready;
   uart_dem_pkg::dii_flit_t debug_out;
   logic                    debug_out_ready;
   logic                    irq;

   int    seed = 2489;
   int    ready_seed = 2489;
   int    checks = 0;
   int    errors = 0;
   int    checks_at;
   int    errors_at;
   string test_name = "reset";
   bit    out_stall;

   // Model state
   uart_dem_pkg::char_t     rx_q[$];
   uart_dem_pkg::char_t     tx_exp[$];    // Characters whose packets must still come out
   uart_dem_pkg::dii_flit_t out_q[$];
   logic [3:0]              m_ier;
   uart_dem_pkg::char_t     m_lcr;
   uart_dem_pkg::char_t     m_scr;

   uart_dem_top DUT (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // Random back-pressure on the outgoing flits
   always @(negedge clk) begin
      if (out_stall) debug_out_ready = 1'b0;
      else debug_out_ready = $random(ready_seed) & 1;
   end

   always @(posedge clk) begin
      if (!rst && debug_out.valid && debug_out_ready) out_q.push_back(debug_out);
   end

   task automatic begin_test(input string name);
      test_name = name;
      checks_at = checks;
      errors_at = errors;
   endtask

   task automatic end_test();
      $display("test %s: %0d checks, %0d errors", test_name, checks - checks_at,
               errors - errors_at);
   endtask

   task automatic abort_run(input string why);
      $display("%s in test %s", why, test_name);
      $display("all tests: %0d checks, %0d errors", checks, errors + 1);
      $display("Test failed");
      $finish;
   endtask

   task automatic check_char(input string what, input uart_dem_pkg::char_t exp,
                             input uart_dem_pkg::char_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %02h, actual %02h", test_name, what, exp, act);
      end
   endtask

   task automatic check_flit(input string what, input uart_dem_pkg::dii_flit_t exp,
                             input uart_dem_pkg::dii_flit_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %05h, actual %05h", test_name, what, exp, act);
      end
   endtask

   task automatic check_irq(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_resp(input string what, input logic [1:0] exp,
                             input logic [1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   function automatic uart_dem_pkg::char_t lsr_model(input bit tx_empty);
      return {1'b0, tx_empty, 1'b1, 4'b0000, rx_q.size() != 0};
   endfunction

   function automatic uart_dem_pkg::char_t iir_model(input bit tx_empty);
      if (m_ier[0] && rx_q.size() != 0) return 8'hC4;
      if (m_ier[1] && tx_empty) return 8'hC2;
      return 8'hC1;
   endfunction

   // Collects one response, holding the ready low for stall cycles while a
   // competing read and write are offered
   task automatic take_resp(input bit is_write, input int stall,
                            output uart_dem_pkg::char_t data);
      int                  edges;
      int                  held;
      bit                  seen;
      bit                  done;
      logic                v;
      uart_dem_pkg::char_t first;
      edges = 0;
      held  = 0;
      seen  = 0;
      done  = 0;
      first = '0;
      @(negedge clk);
      ar_valid = 1'b0;
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      if (stall > 0) begin
         ar_addr  = 3'd7;
         aw_addr  = 3'd7;
         w_data   = $random(seed);
         ar_valid = 1'b1;
         aw_valid = 1'b1;
         w_valid  = 1'b1;
      end
      r_ready = !is_write && stall == 0;
      b_ready = is_write && stall == 0;
      while (!done) begin
         @(posedge clk);
         edges++;
         v = is_write ? b_valid : r_valid;
         if (ar_ready || aw_ready || w_ready) begin
            errors++;
            $display("A second transaction was accepted while one was outstanding");
         end
         if (v && !seen) begin
            seen  = 1;
            first = r_data;
            if (edges != 3) begin
               errors++;
               $display("The response rose %0d cycles after the handshake", edges - 1);
            end
         end else if (seen && !v) begin
            errors++;
            $display("The response valid dropped before the host took it");
         end
         if (v && (is_write ? b_ready : r_ready)) begin
            data = r_data;
            done = 1;
            if (is_write) check_resp("b_resp", 2'b00, b_resp);
            else check_resp("r_resp", 2'b00, r_resp);
         end else begin
            if (seen) held++;
            if (seen && !is_write) check_char("read data while stalled", first, r_data);
            if (edges > TIMEOUT) abort_run("No response arrived");
            @(negedge clk);
            if (seen && held >= stall) begin
               r_ready  = !is_write;
               b_ready  = is_write;
               ar_valid = 1'b0;
               aw_valid = 1'b0;
               w_valid  = 1'b0;
            end
         end
      end
   endtask

   task automatic axi_write(input uart_dem_pkg::reg_addr_t addr,
                            input uart_dem_pkg::char_t data, input int stall);
      int                  waited;
      uart_dem_pkg::char_t unused;
      waited = 0;
      @(negedge clk);
      aw_addr  = addr;
      w_data   = data;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      do begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT) abort_run("The write was never accepted");
      end while (!(aw_ready && w_ready));
      take_resp(1'b1, stall, unused);
   endtask

   task automatic axi_read(input uart_dem_pkg::reg_addr_t addr,
                           output uart_dem_pkg::char_t data, input int stall);
      int waited;
      waited = 0;
      @(negedge clk);
      ar_addr  = addr;
      ar_valid = 1'b1;
      do begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT) abort_run("The read was never accepted");
      end while (!ar_ready);
      take_resp(1'b0, stall, data);
   endtask

   // Sends one DII packet with len payload characters and updates the model
   task automatic inject_packet(input int len);
      uart_dem_pkg::dii_flit_t f;
      int                      n;
      int                      waited;
      for (n = 0; n < HDR + len; n++) begin
         @(negedge clk);
         if (($random(seed) & 3) == 0) begin
            debug_in.valid = 1'b0;   // Idle cycle inside the packet
            @(negedge clk);
         end
         f.valid  = 1'b1;
         f.last   = (n == HDR + len - 1);
         f.data   = $random(seed);
         debug_in = f;
         waited   = 0;
         do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("An incoming flit was never accepted");
         end while (!debug_in_ready);
         if (n >= HDR && rx_q.size() < RX_DEPTH) rx_q.push_back(f.data[7:0]);
      end
      @(negedge clk);
      debug_in.valid = 1'b0;
   endtask

   task automatic empty_rx();
      uart_dem_pkg::char_t rd;
      while (rx_q.size() > 0) begin
         axi_read(3'd0, rd, 0);
         check_char("RBR", rx_q.pop_front(), rd);
      end
   endtask

   // Waits for every expected packet and checks it flit by flit
   task automatic drain_tx();
      uart_dem_pkg::dii_flit_t exp;
      uart_dem_pkg::char_t     c;
      int                      waited;
      int                      k;
      waited = 0;
      while (out_q.size() < 4 * tx_exp.size()) begin
         @(negedge clk);
         waited++;
         if (waited > 4000) abort_run("Outgoing packets stopped arriving");
      end
      repeat (20) @(negedge clk);   // Room for stray flits to show up
      while (tx_exp.size() > 0) begin
         c = tx_exp.pop_front();
         for (k = 0; k < 4; k++) begin
            exp.valid = 1'b1;
            exp.last  = (k == 3);
            case (k)
               0:       exp.data = `UART_DEM_HOST_ID;
               1:       exp.data = id;
               2:       exp.data = `UART_DEM_EVT_TYPE;
               default: exp.data = {8'h00, c};
            endcase
            check_flit("outgoing flit", exp, out_q.pop_front());
         end
      end
      if (out_q.size() != 0) begin
         errors++;
         $display("%0d unexpected flits came out in test %s", out_q.size(), test_name);
         out_q.delete();
      end
   endtask

   initial begin
      uart_dem_pkg::char_t v;
      uart_dem_pkg::char_t rd;
      uart_dem_pkg::char_t dll;
      uart_dem_pkg::char_t dlm;
      uart_dem_pkg::char_t iir_exp;
      int                  n;
      int                  i;
      int                  stall;
      bit                  tx_busy;
      rst             = 1'b1;
      id              = $random(seed);
      ar_addr         = '0;
      ar_valid        = 1'b0;
      aw_addr         = '0;
      aw_valid        = 1'b0;
      w_data          = '0;
      w_valid         = 1'b0;
      r_ready         = 1'b0;
      b_ready         = 1'b0;
      debug_in        = '0;
      debug_out_ready = 1'b0;
      out_stall       = 1'b0;
      m_ier           = '0;
      m_lcr           = '0;
      m_scr           = '0;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      begin_test("reset");
      @(negedge clk);
      check_irq("ar_ready", 1'b0, ar_ready);
      check_irq("aw_ready", 1'b0, aw_ready);
      check_irq("w_ready", 1'b0, w_ready);
      check_irq("r_valid", 1'b0, r_valid);
      check_irq("b_valid", 1'b0, b_valid);
      check_irq("debug_out.valid", 1'b0, debug_out.valid);
      check_irq("irq", 1'b0, irq);
      check_irq("debug_in_ready", 1'b1, debug_in_ready);
      end_test();

      begin_test("readback");
      repeat (3) begin
         m_scr = $random(seed);
         axi_write(3'd7, m_scr, 0);
         axi_read(3'd7, rd, 0);
         check_char("SCR", m_scr, rd);
         m_lcr = $random(seed) & 8'h7F;
         axi_write(3'd3, m_lcr, 0);
         axi_read(3'd3, rd, 0);
         check_char("LCR", m_lcr, rd);
         v = $random(seed);
         m_ier = v[3:0];
         axi_write(3'd1, v, 0);
         axi_read(3'd1, rd, 0);
         check_char("IER", {4'h0, m_ier}, rd);
         v = $random(seed);
         axi_write(3'd4, v, 0);
         axi_read(3'd4, rd, 0);
         check_char("MCR", v & 8'h1F, rd);
         dll = $random(seed);
         dlm = $random(seed);
         axi_write(3'd3, m_lcr | 8'h80, 0);   // DLAB on
         axi_write(3'd0, dll, 0);
         axi_write(3'd1, dlm, 0);
         axi_read(3'd0, rd, 0);
         check_char("DLL", dll, rd);
         axi_read(3'd1, rd, 0);
         check_char("DLM", dlm, rd);
         axi_read(3'd3, rd, 0);
         check_char("LCR with DLAB", m_lcr | 8'h80, rd);
         axi_write(3'd3, m_lcr, 0);
         axi_read(3'd1, rd, 0);
         check_char("IER after DLM", {4'h0, m_ier}, rd);
         axi_read(3'd6, rd, 0);
         check_char("MSR", 8'hB0, rd);
      end
      m_ier = '0;
      axi_write(3'd1, 8'h00, 0);
      drain_tx();   // Divisor writes must not have sent anything
      end_test();

      begin_test("transmit");
      repeat (4) begin
         n = 1 + ($random(seed) & 15);
         for (i = 0; i < n; i++) begin
            v = $random(seed);
            axi_write(3'd0, v, 0);
            tx_exp.push_back(v);
         end
         drain_tx();
         axi_read(3'd5, rd, 0);
         check_char("LSR", lsr_model(1'b1), rd);
      end
      end_test();

      begin_test("receive");
      repeat (6) begin
         n = 1 + ($random(seed) & 3);
         repeat (n) inject_packet(1 + ($random(seed) & 7));
         axi_read(3'd5, rd, 0);
         check_char("LSR", lsr_model(1'b1), rd);
         n = {$random(seed)} % (rx_q.size() + 3);
         repeat (n) begin
            axi_read(3'd0, rd, 0);
            check_char("RBR", (rx_q.size() != 0) ? rx_q.pop_front() : 8'h00, rd);
         end
         axi_read(3'd5, rd, 0);
         check_char("LSR", lsr_model(1'b1), rd);
      end
      inject_packet(RX_DEPTH + 4);   // More payload than the receive FIFO holds
      empty_rx();
      axi_read(3'd0, rd, 0);
      check_char("RBR when empty", 8'h00, rd);
      end_test();

      begin_test("interrupt");
      repeat (10) begin
         v = $random(seed);
         m_ier = v[3:0];
         axi_write(3'd1, v, 0);
         if ($random(seed) & 1) inject_packet(1 + ($random(seed) & 3));
         else empty_rx();
         tx_busy = $random(seed) & 1;
         if (tx_busy) begin
            // Two or more characters keep the transmit FIFO occupied
            out_stall = 1'b1;
            repeat (2) @(negedge clk);
            n = 2 + ($random(seed) & 3);
            for (i = 0; i < n; i++) begin
               v = $random(seed);
               axi_write(3'd0, v, 0);
               tx_exp.push_back(v);
            end
         end
         iir_exp = iir_model(!tx_busy);
         axi_read(3'd2, rd, 0);
         check_char("IIR", iir_exp, rd);
         @(negedge clk);
         check_irq("irq", !iir_exp[0], irq);
         out_stall = 1'b0;
         drain_tx();
      end
      m_ier = '0;
      axi_write(3'd1, 8'h00, 0);
      empty_rx();
      end_test();

      begin_test("clear");
      out_stall = 1'b1;
      repeat (2) @(negedge clk);
      n = 3 + ($random(seed) & 3);
      for (i = 0; i < n; i++) begin
         v = $random(seed);
         axi_write(3'd0, v, 0);
         // The first packet is buffered and the second already being built
         if (i < 2) tx_exp.push_back(v);
      end
      inject_packet(2 + ($random(seed) & 3));
      axi_write(3'd2, 8'h06, 0);
      rx_q.delete();
      axi_read(3'd5, rd, 0);
      check_char("LSR after clear", lsr_model(1'b1), rd);
      axi_read(3'd0, rd, 0);
      check_char("RBR after clear", 8'h00, rd);
      out_stall = 1'b0;
      drain_tx();
      end_test();

      begin_test("backpressure");
      repeat (20) begin
         stall = 1 + ($random(seed) & 7);
         case ({$random(seed)} % 4)
            0: begin
               m_scr = $random(seed);
               axi_write(3'd7, m_scr, stall);
            end
            1: begin
               axi_read(3'd7, rd, stall);
               check_char("SCR", m_scr, rd);
            end
            2: begin
               axi_read(3'd5, rd, stall);
               check_char("LSR", lsr_model(1'b1), rd);
            end
            default: begin
               inject_packet(1 + ($random(seed) & 3));
               axi_read(3'd0, rd, stall);
               check_char("RBR", rx_q.pop_front(), rd);
            end
         endcase
      end
      axi_read(3'd7, rd, 0);
      check_char("SCR at end", m_scr, rd);
      empty_rx();
      end_test();

      $display("all tests: %0d checks, %0d errors", checks, errors);
      if (errors == 0) $display("Test passed");
      else $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/uart_dem_pkg.sv
rtl/uart_dem_fifo.sv
rtl/uart_16550_regs.sv
rtl/uart_dii_bridge.sv
rtl/uart_nasti_bridge.sv
rtl/uart_dem_top.sv
dv/uart_dem_tb.sv

// File: Bender.yml
package:
  name: uart_dem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/uart_dem_pkg.sv
      - rtl/uart_dem_fifo.sv
      - rtl/uart_16550_regs.sv
      - rtl/uart_dii_bridge.sv
      - rtl/uart_nasti_bridge.sv
      - rtl/uart_dem_top.sv
      - target: test
        files:
          - dv/uart_dem_tb.sv
